//--- logic/fpCompare.sv
/*
  FP compare
  feq, flt, fle, fmin and fmax with NaN handling and the
  invalid flag
*/
`timescale 1ns/1ps
`include "fpu_cfg.svh"

module fpCompare (
  input  fpPkg::fpOpE   opE,
  input  fpPkg::fpWord  x, y,
  fpUnpackedIf.user     u,
  output fpPkg::fpWord  cmpFpRes,   // min/max
  output fpPkg::intWord cmpIntRes,  // 0 or 1
  output logic          cmpNV
);
  import fpPkg::*;

  logic [`FPU_NE+`FPU_NF:0] magX, magY; // Exponent then mantissa
  logic anyNan, anySNan;
  logic bothZero;
  logic same;        // Bit-identical
  logic ordLt;       // x below y, -0 below +0
  logic res;

  assign magX     = {u.exp[0], u.mant[0]};
  assign magY     = {u.exp[1], u.mant[1]};
  assign anyNan   = |u.nan;
  assign anySNan  = |u.sNan;
  assign bothZero = &u.zero;
  assign same     = (x == y);

  // Sign first, then magnitude, reversed when both negative
  assign ordLt = (u.sign[0] != u.sign[1]) ? u.sign[0] :
                 u.sign[0] ? (magY < magX) : (magX < magY);

  always_comb begin
    case (opE)
      FEQ:     res = ~anyNan & (same | bothZero); // Signed zeros equal here
      FLT:     res = ~anyNan & ~bothZero & ordLt;
      FLE:     res = ~anyNan & (same | bothZero | ordLt);
      default: res = 1'b0;
    endcase
    case (opE)
      FEQ, MIN, MAX: cmpNV = anySNan;
      FLT, FLE:      cmpNV = anyNan;  // Signaling compares
      default:       cmpNV = 1'b0;
    endcase
    if (&u.nan)          cmpFpRes = `FPU_CANON_NAN;
    else if (u.nan[0])   cmpFpRes = y;   // Single NaN gives the other one
    else if (u.nan[1])   cmpFpRes = x;
    else if (opE == MAX) cmpFpRes = ordLt ? y : x;
    else                 cmpFpRes = ordLt ? x : y;
  end

  assign cmpIntRes = {{(`FPU_XLEN-1){1'b0}}, res};
endmodule

//--- logic/fpExecute.sv
/*
  FP execute stage
  Unpacks the operands, runs compare, sign injection,
  fclass and moves, and selects the FP result, the
  integer result and the flags
*/
`timescale 1ns/1ps
`include "fpu_cfg.svh"

module fpExecute (
  input  fpPkg::fpOpE   opE,
  input  fpPkg::fpWord  x, y,
  input  fpPkg::intWord srcAE,
  output fpPkg::fpWord  fpResE,
  output fpPkg::intWord intResE,
  output fpPkg::fpFlags flagsE
);
  import fpPkg::*;

  fpUnpackedIf uIf ();
  fpWord  cmpFpRes;
  intWord cmpIntRes;
  logic   cmpNV;
  logic   sgnBit;       // Injected sign
  logic   normal;       // X is a normal number
  logic   pos, neg;
  logic [9:0] classMask;

  fpUnpack  unpack (.x, .y, .u(uIf.unpacker));
  fpCompare cmp (.opE, .x, .y, .u(uIf.user), .cmpFpRes, .cmpIntRes, .cmpNV);

  ////////////////////
  // Sign injection
  always_comb begin
    case (opE)
      SGNJN:   sgnBit = ~uIf.sign[1];
      SGNJX:   sgnBit = uIf.sign[0] ^ uIf.sign[1];
      default: sgnBit = uIf.sign[1];  // fsgnj
    endcase
  end

  ////////////////////
  // fclass, one-hot
  assign normal = ~(uIf.zero[0] | uIf.subnorm[0] | uIf.inf[0] | uIf.nan[0]);
  assign neg = uIf.sign[0];
  assign pos = ~uIf.sign[0];
  assign classMask = {uIf.nan[0] & ~uIf.sNan[0],  // 9 quiet NaN
                      uIf.sNan[0],                // 8 signaling NaN
                      pos & uIf.inf[0],
                      pos & normal,
                      pos & uIf.subnorm[0],
                      pos & uIf.zero[0],
                      neg & uIf.zero[0],
                      neg & uIf.subnorm[0],
                      neg & normal,
                      neg & uIf.inf[0]};          // 0 minus infinity

  // Result selects
  always_comb begin
    case (opE)
      SGNJ, SGNJN, SGNJX: fpResE = {sgnBit, x[`FPU_FLEN-2:0]};
      MIN, MAX:           fpResE = cmpFpRes;
      MVWX:               fpResE = srcAE;  // Raw bits, no conversion
      default:            fpResE = '0;
    endcase
    case (opE)
      FEQ, FLT, FLE: intResE = cmpIntRes;
      CLASS:         intResE = {{(`FPU_XLEN-10){1'b0}}, classMask};
      MVXW:          intResE = x;
      default:       intResE = '0;
    endcase
    flagsE = '0;
    flagsE[`FPU_FLAG_NV] = cmpNV; // Only compare ops can go invalid
  end
endmodule

//--- logic/fpHazard.sv
/*
  FP hazard unit
  Picks the forwarding source of each E operand and raises
  the decode stall on a load-use dependence
*/
`timescale 1ns/1ps

module fpHazard (
  input  fpPkg::regAdr  rs1D, rs2D, rs1E, rs2E,
  input  fpPkg::regAdr  rdE, rdM, rdW,
  input  logic          useXD, useYD,
  input  fpPkg::fpOpE   opE, opM,
  input  logic          fRegWriteM, fRegWriteW,
  output fpPkg::fwdSelE fwdXE, fwdYE,
  output logic          fpuStallD
);
  import fpPkg::*;

  logic fwdFromM; // M result exists in E timing
  assign fwdFromM = fRegWriteM && (opM != LOAD); // Load data only shows up in W

  // M is newer than W so it wins
  always_comb begin
    fwdXE = FROM_REG;
    fwdYE = FROM_REG;
    if (fwdFromM && rs1E == rdM)        fwdXE = FROM_M;
    else if (fRegWriteW && rs1E == rdW) fwdXE = FROM_W;
    if (fwdFromM && rs2E == rdM)        fwdYE = FROM_M;
    else if (fRegWriteW && rs2E == rdW) fwdYE = FROM_W;
  end

  // Consumer right behind a flw waits one cycle
  assign fpuStallD = (opE == LOAD) &&
                     ((useXD && rs1D == rdE) || (useYD && rs2D == rdE));
endmodule

//--- logic/fpPkg.sv
/*
  FP unit shared types
  Word and address types, the operation enum carried down the
  pipeline, forwarding selects and the flag vector
*/
`include "fpu_cfg.svh"

package fpPkg;

  typedef logic [`FPU_FLEN-1:0] fpWord;  // One FP value
  typedef logic [`FPU_XLEN-1:0] intWord; // One integer value
  typedef logic [4:0]           regAdr;  // FP register address

  // Operation decoded in D and carried to W
  typedef enum logic [3:0] {
    NONE,   // Bubble or illegal
    SGNJ,
    SGNJN,
    SGNJX,
    MIN,
    MAX,
    FEQ,
    FLT,
    FLE,
    CLASS,
    MVXW,   // FP reg to int reg
    MVWX,   // Int reg to FP reg
    LOAD,
    STORE
  } fpOpE;

  // Operand source in E
  typedef enum logic [1:0] {
    FROM_REG,
    FROM_W,
    FROM_M
  } fwdSelE;

  typedef logic [4:0] fpFlags; // NV DZ OF UF NX

endpackage

//--- logic/fpRegFile.sv
/*
  FP register file
  32 words, two combinational read ports and one write port
  with write-to-read bypass
*/
`timescale 1ns/1ps
`include "fpu_cfg.svh"

module fpRegFile (
  input  logic         clk,
  input  fpPkg::regAdr rs1, rs2,
  input  fpPkg::regAdr wrAdr,
  input  logic         we,
  input  fpPkg::fpWord wd,
  output fpPkg::fpWord rd1, rd2
);
  import fpPkg::*;

  fpWord mem [`FPU_NREGS];

  always_ff @(posedge clk) begin
    if (we) mem[wrAdr] <= wd;
  end

  // Same-cycle write shows up on the read port
  assign rd1 = (we && rs1 == wrAdr) ? wd : mem[rs1];
  assign rd2 = (we && rs2 == wrAdr) ? wd : mem[rs2];
endmodule

//--- logic/fpUnpack.sv
/*
  FP unpacker
  Splits X and Y into sign, exponent and mantissa and
  classifies zero, infinity, NaN, sNaN and subnormal
*/
`timescale 1ns/1ps
`include "fpu_cfg.svh"

module fpUnpack (
  input  fpPkg::fpWord  x, y,
  fpUnpackedIf.unpacker u
);
  import fpPkg::*;

  fpWord      ops [2];    // 0 is X, 1 is Y
  logic [1:0] expZero;
  logic [1:0] expMax;     // All ones exponent
  logic [1:0] fracZero;

  assign ops[0] = x;
  assign ops[1] = y;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      expZero[i]   = ~|ops[i][`FPU_FLEN-2 -: `FPU_NE];
      expMax[i]    = &ops[i][`FPU_FLEN-2 -: `FPU_NE];
      fracZero[i]  = ~|ops[i][`FPU_NF-1:0];
      u.sign[i]    = ops[i][`FPU_FLEN-1];
      u.exp[i]     = ops[i][`FPU_FLEN-2 -: `FPU_NE];
      u.mant[i]    = {~expZero[i], ops[i][`FPU_NF-1:0]}; // Hidden bit
      u.zero[i]    = expZero[i] & fracZero[i];
      u.subnorm[i] = expZero[i] & ~fracZero[i];
      u.inf[i]     = expMax[i] & fracZero[i];
      u.nan[i]     = expMax[i] & ~fracZero[i];
      u.sNan[i]    = expMax[i] & ~fracZero[i] & ~ops[i][`FPU_NF-1]; // Quiet bit clear
    end
  end
endmodule

//--- logic/fpUnpackedIf.sv
/*
  Unpacked operand bundle
  Fields and class bits of X (index 0) and Y (index 1)
*/
`timescale 1ns/1ps
`include "fpu_cfg.svh"

interface fpUnpackedIf;
  logic [1:0]                  sign;
  logic [1:0][`FPU_NE-1:0]     exp;     // Biased exponent
  logic [1:0][`FPU_NF:0]       mant;    // Hidden bit plus fraction
  logic [1:0]                  zero;
  logic [1:0]                  inf;
  logic [1:0]                  nan;     // Any NaN
  logic [1:0]                  sNan;    // Signaling NaN
  logic [1:0]                  subnorm;

  modport unpacker (output sign, exp, mant, zero, inf, nan, sNan, subnorm);
  modport user (input sign, exp, mant, zero, inf, nan, sNan, subnorm);
endinterface

//--- logic/fpu.sv
/*
  FP unit top level
  Four-stage single-precision FPU: decode and register read,
  execute with forwarding, memory result registers and
  writeback select between the FP result and load data
*/
`timescale 1ns/1ps

module fpu (
  input  logic          clk,
  input  logic          rst,
  input  logic          stallE, stallM, stallW,  // From core hazard unit
  input  logic          flushE, flushM, flushW,
  input  logic [1:0]    statusFs,                // FS field, 0 means FP off
  input  logic [31:0]   instrD,
  input  fpPkg::intWord srcAE,                   // Integer operand for fmv.w.x
  input  fpPkg::fpWord  readDataW,               // Load data from LSU
  output logic          fpuStallD,
  output logic          illegalInstrD,
  output logic          fWriteIntE,
  output logic          fRegWriteM,
  output logic          fWriteIntM,
  output logic          fpLoadStoreM,
  output fpPkg::fpWord  fWriteDataM,             // Store data to LSU
  output fpPkg::intWord fIntResM,                // To integer register file
  output fpPkg::fpFlags setFflagsM
);
  import fpPkg::*;

  regAdr  rs1D, rs2D, rs1E, rs2E;
  regAdr  rdE, rdM, rdW;
  logic   useXD, useYD;              // Sources read in D
  fpOpE   opE, opM, opW;
  logic   fRegWriteW;
  fpWord  rd1D, rd2D, rd1E, rd2E;    // Register file reads
  fpWord  xE, yE;                    // Operands after forwarding
  fwdSelE fwdXE, fwdYE;
  fpWord  fpResE, fpResM, fpResW;
  fpWord  fResultW;                  // Final value written to the FP regs
  intWord intResE;
  fpFlags flagsE;

  // Three-way operand select
  function automatic fpWord fwdPick(fwdSelE sel, fpWord regVal, fpWord wVal, fpWord mVal);
    case (sel)
      FROM_M:  return mVal;
      FROM_W:  return wVal;
      default: return regVal;
    endcase
  endfunction

  ////////////////////
  // Decode
  fpuCtrl ctrl (.clk, .rst, .stallE, .stallM, .stallW, .flushE, .flushM, .flushW,
    .instrD, .statusFs, .illegalInstrD, .opE, .opM, .opW,
    .rs1D, .rs2D, .rs1E, .rs2E, .rdE, .rdM, .rdW, .useXD, .useYD,
    .fRegWriteM, .fRegWriteW, .fWriteIntE, .fWriteIntM, .fpLoadStoreM);

  fpRegFile regs (.clk, .rs1(rs1D), .rs2(rs2D), .wrAdr(rdW), .we(fRegWriteW),
    .wd(fResultW), .rd1(rd1D), .rd2(rd2D));

  // D/E operand registers
  always_ff @(posedge clk) begin
    if (!stallE) begin
      rd1E <= rd1D;
      rd2E <= rd2D;
    end
  end

  ////////////////////
  // Execute
  fpHazard hazard (.rs1D, .rs2D, .rs1E, .rs2E, .rdE, .rdM, .rdW, .useXD, .useYD,
    .opE, .opM, .fRegWriteM, .fRegWriteW, .fwdXE, .fwdYE, .fpuStallD);

  assign xE = fwdPick(fwdXE, rd1E, fResultW, fpResM);
  assign yE = fwdPick(fwdYE, rd2E, fResultW, fpResM); // Also the store data

  fpExecute exec (.opE, .x(xE), .y(yE), .srcAE, .fpResE, .intResE, .flagsE);

  // E/M registers
  always_ff @(posedge clk) begin
    if (rst || flushM) setFflagsM <= '0;
    else if (!stallM)  setFflagsM <= flagsE;
  end

  always_ff @(posedge clk) begin
    if (!stallM) begin
      fpResM      <= fpResE;
      fIntResM    <= intResE;
      fWriteDataM <= yE;
    end
  end

  ////////////////////
  // Memory to writeback
  always_ff @(posedge clk) begin
    if (!stallW) fpResW <= fpResM;
  end

  assign fResultW = (opW == LOAD) ? readDataW : fpResW; // Loads bypass the FP result
endmodule

//--- logic/fpuCtrl.sv
/*
  FP control
  Decodes flw, fsw and the supported OP-FP encodings into an
  operation, flags illegal ones and carries op and register
  addresses from execute down to writeback
*/
`timescale 1ns/1ps

module fpuCtrl (
  input  logic        clk,
  input  logic        rst,
  input  logic        stallE, stallM, stallW,
  input  logic        flushE, flushM, flushW,
  input  logic [31:0] instrD,
  input  logic [1:0]  statusFs,
  output logic        illegalInstrD,
  output fpPkg::fpOpE opE, opM, opW,
  output fpPkg::regAdr rs1D, rs2D, rs1E, rs2E,
  output fpPkg::regAdr rdE, rdM, rdW,
  output logic        useXD, useYD,     // FP sources needed by the D instruction
  output logic        fRegWriteM, fRegWriteW,
  output logic        fWriteIntE, fWriteIntM,
  output logic        fpLoadStoreM
);
  import fpPkg::*;

  fpOpE  rawOpD;   // Before the FS gate
  fpOpE  opD;
  regAdr rdD;
  logic [6:0] funct7;
  logic [2:0] funct3;

  // Result goes to the integer register file
  function automatic logic isIntWrite(fpOpE op);
    return op inside {FEQ, FLT, FLE, CLASS, MVXW};
  endfunction

  // Result goes to the FP register file
  function automatic logic isFpWrite(fpOpE op);
    return op inside {SGNJ, SGNJN, SGNJX, MIN, MAX, MVWX, LOAD};
  endfunction

  assign funct7 = instrD[31:25];
  assign funct3 = instrD[14:12];
  assign rs1D   = instrD[19:15];
  assign rs2D   = instrD[24:20];
  assign rdD    = instrD[11:7];

  always_comb begin
    rawOpD = NONE; // Anything unmatched is illegal
    case (instrD[6:0])
      7'b0000111: if (funct3 == 3'b010) rawOpD = LOAD;   // flw
      7'b0100111: if (funct3 == 3'b010) rawOpD = STORE;  // fsw
      7'b1010011: begin                                  // OP-FP
        case (funct7)
          7'b0010000: case (funct3)
            3'b000: rawOpD = SGNJ;
            3'b001: rawOpD = SGNJN;
            3'b010: rawOpD = SGNJX;
            default: rawOpD = NONE;
          endcase
          7'b0010100: if (funct3 == 3'b000) rawOpD = MIN;
                      else if (funct3 == 3'b001) rawOpD = MAX;
          7'b1010000: case (funct3)
            3'b010: rawOpD = FEQ;
            3'b001: rawOpD = FLT;
            3'b000: rawOpD = FLE;
            default: rawOpD = NONE;
          endcase
          7'b1110000: if (rs2D == '0 && funct3 == 3'b000) rawOpD = MVXW;
                      else if (rs2D == '0 && funct3 == 3'b001) rawOpD = CLASS;
          7'b1111000: if (rs2D == '0 && funct3 == 3'b000) rawOpD = MVWX;
          default: rawOpD = NONE;
        endcase
      end
      default: rawOpD = NONE;
    endcase
  end

  assign illegalInstrD = (statusFs == 2'b00) || (rawOpD == NONE); // FP off traps everything
  assign opD = illegalInstrD ? NONE : rawOpD;
  assign useXD = opD inside {SGNJ, SGNJN, SGNJX, MIN, MAX, FEQ, FLT, FLE, CLASS, MVXW};
  assign useYD = opD inside {SGNJ, SGNJN, SGNJX, MIN, MAX, FEQ, FLT, FLE, STORE};

  ////////////////////
  // Control pipeline
  always_ff @(posedge clk) begin
    if (rst || flushE) begin
      opE  <= NONE;
      rdE  <= '0;
      rs1E <= '0;
      rs2E <= '0;
    end else if (!stallE) begin
      opE  <= opD;
      rdE  <= rdD;
      rs1E <= rs1D;
      rs2E <= rs2D;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flushM) begin
      opM <= NONE;
      rdM <= '0;
    end else if (!stallM) begin
      opM <= opE;
      rdM <= rdE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flushW) begin
      opW <= NONE;
      rdW <= '0;
    end else if (!stallW) begin
      opW <= opM;
      rdW <= rdM;
    end
  end

  assign fWriteIntE   = isIntWrite(opE);
  assign fWriteIntM   = isIntWrite(opM);
  assign fRegWriteM   = isFpWrite(opM);
  assign fRegWriteW   = isFpWrite(opW);
  assign fpLoadStoreM = opM inside {LOAD, STORE}; // Tells the LSU to use FP data
endmodule

//--- logic/fpu_cfg.svh
/*
  FPU configuration
  Word widths, field sizes and fixed constants of the
  single-precision FP unit
*/
`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

// Word widths
`define FPU_XLEN 32
`define FPU_FLEN 32

// IEEE single fields
`define FPU_NE 8
`define FPU_NF 23

`define FPU_NREGS 32              // FP register count
`define FPU_CANON_NAN 32'h7fc00000 // Canonical quiet NaN
`define FPU_FLAG_NV 4              // Invalid flag position in fflags

`endif

//--- run.sh
#!/usr/bin/env bash
# Compile and run the FP unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f verilog.f --top-module fpuTb -o fpuSim
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/fpuSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0

//--- test/fpuTb.sv
/*
  FP unit testbench
  Table-driven self-checking bench. Rows go into decode one per
  cycle and their M-stage results are compared with expected values,
  followed by directed stall and flush checks
*/
`timescale 1ns/1ps

module fpuTb;
  import fpPkg::*;

  localparam fpFlags NV_SET = 5'b10000; // Invalid only
  localparam fpFlags NO_FLG = 5'b00000;

  typedef struct {
    logic [31:0] instr;
    logic        fsOff;      // Run with statusFs zero
    fpOpE        op;
    intWord      srcA;
    fpWord       rdata;      // Load data for readDataW
    intWord      expInt;
    fpWord       expData;
    fpFlags      expFlags;
    logic        expWrite;
    logic        expIllegal;
  } rowT;

  logic clk, rst;
  logic stallE, stallM, stallW, flushE, flushM, flushW;
  logic [1:0] statusFs;
  logic [31:0] instrD;
  intWord srcAE, fIntResM;
  fpWord readDataW, fWriteDataM;
  logic fpuStallD, illegalInstrD, fWriteIntE, fRegWriteM, fWriteIntM, fpLoadStoreM;
  fpFlags setFflagsM;

  rowT rows[$];
  int errors = 0;
  int stalls = 0;
  int nRows = 0;
  logic tableReady = 1'b0;
  logic [31:0] lfsr = 32'hc2d4_db44;

  fpu UUT (.clk, .rst, .stallE, .stallM, .stallW, .flushE, .flushM, .flushW,
    .statusFs, .instrD, .srcAE, .readDataW, .fpuStallD, .illegalInstrD, .fWriteIntE,
    .fRegWriteM, .fWriteIntM, .fpLoadStoreM, .fWriteDataM, .fIntResM, .setFflagsM);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  ////////////////////
  // Helpers
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // x^32+x^22+x^2+x+1
  endfunction

  // One LFSR step per bit taken
  task automatic randWord(output logic [31:0] v);
    v = 32'h0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsrStep(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // RV32F encodings with addi x0,x0,0 for anything else
  function automatic logic [31:0] encode(input fpOpE op, input regAdr rd, rs1, rs2);
    case (op)
      LOAD:    return {12'd0, 5'd0, 3'b010, rd, 7'b0000111};
      STORE:   return {7'd0, rs2, 5'd0, 3'b010, 5'd0, 7'b0100111};
      SGNJ:    return {7'b0010000, rs2, rs1, 3'b000, rd, 7'b1010011};
      SGNJN:   return {7'b0010000, rs2, rs1, 3'b001, rd, 7'b1010011};
      SGNJX:   return {7'b0010000, rs2, rs1, 3'b010, rd, 7'b1010011};
      MIN:     return {7'b0010100, rs2, rs1, 3'b000, rd, 7'b1010011};
      MAX:     return {7'b0010100, rs2, rs1, 3'b001, rd, 7'b1010011};
      FEQ:     return {7'b1010000, rs2, rs1, 3'b010, rd, 7'b1010011};
      FLT:     return {7'b1010000, rs2, rs1, 3'b001, rd, 7'b1010011};
      FLE:     return {7'b1010000, rs2, rs1, 3'b000, rd, 7'b1010011};
      MVXW:    return {7'b1110000, 5'd0, rs1, 3'b000, rd, 7'b1010011};
      CLASS:   return {7'b1110000, 5'd0, rs1, 3'b001, rd, 7'b1010011};
      MVWX:    return {7'b1111000, 5'd0, rs1, 3'b000, rd, 7'b1010011};
      default: return 32'h0000_0013;
    endcase
  endfunction

  task automatic addRow(input fpOpE op, input regAdr rd, rs1, rs2, input intWord srcA,
                        input fpWord rdata, input intWord expInt, input fpWord expData,
                        input fpFlags fl, input logic wr, input logic fsOff);
    rowT row;
    row.instr      = encode(op, rd, rs1, rs2);
    row.fsOff      = fsOff;
    row.op         = op;
    row.srcA       = srcA;
    row.rdata      = rdata;
    row.expInt     = expInt;
    row.expData    = expData;
    row.expFlags   = fl;
    row.expWrite   = wr;
    row.expIllegal = fsOff || (op == NONE);
    rows.push_back(row);
  endtask

  task automatic putFp(input regAdr rd, input intWord v);   // fmv.w.x
    addRow(MVWX, rd, 5'd0, 5'd0, v, 32'h0, 32'h0, 32'h0, NO_FLG, 1'b1, 1'b0);
  endtask

  task automatic getFp(input regAdr rs, input intWord exp); // fmv.x.w
    addRow(MVXW, 5'd0, rs, 5'd0, 32'h0, 32'h0, exp, 32'h0, NO_FLG, 1'b0, 1'b0);
  endtask

  task automatic fpOp(input fpOpE op, input regAdr rd, rs1, rs2, input fpFlags fl);
    addRow(op, rd, rs1, rs2, 32'h0, 32'h0, 32'h0, 32'h0, fl, 1'b1, 1'b0);
  endtask

  task automatic cmpOp(input fpOpE op, input regAdr rs1, rs2, input intWord res,
                       input fpFlags fl);
    addRow(op, 5'd0, rs1, rs2, 32'h0, 32'h0, res, 32'h0, fl, 1'b0, 1'b0);
  endtask

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  ////////////////////
  // Stimulus table
  task automatic buildTable();
    logic [31:0] v [5];
    logic [31:0] w;
    logic [31:0] clsVal [10] = '{32'hff800000, 32'hbf800000, 32'h80000001, 32'h80000000,
      32'h00000000, 32'h00000001, 32'h3f800000, 32'h7f800000, 32'h7f800001, 32'h7fc00000};
    for (int i = 0; i < 5; i++) randWord(v[i]);
    randWord(w);
    for (int i = 1; i < 5; i++) putFp(regAdr'(i), v[i]);
    addRow(LOAD, 5'd5, 5'd0, 5'd0, 32'h0, v[0], 32'h0, 32'h0, NO_FLG, 1'b1, 1'b0);
    getFp(5'd5, v[0]);                 // Load-use gives one stall
    for (int i = 1; i < 5; i++) getFp(regAdr'(i), v[i]);
    addRow(STORE, 5'd0, 5'd0, 5'd1, 32'h0, 32'h0, 32'h0, v[1], NO_FLG, 1'b0, 1'b0);
    // Forwarding at distance 1 and 2 before a spaced read
    putFp(5'd7, w);
    fpOp(SGNJ, 5'd8, 5'd7, 5'd7, NO_FLG);
    getFp(5'd8, w);
    putFp(5'd9, ~w);
    getFp(5'd1, v[1]);
    getFp(5'd9, ~w);
    getFp(5'd9, ~w);
    // Sign injection on +1.5 and -2.0
    putFp(5'd10, 32'h3fc00000);
    putFp(5'd11, 32'hc0000000);
    fpOp(SGNJ, 5'd12, 5'd10, 5'd11, NO_FLG);
    getFp(5'd12, 32'hbfc00000);
    fpOp(SGNJN, 5'd13, 5'd10, 5'd10, NO_FLG);
    fpOp(SGNJX, 5'd14, 5'd11, 5'd11, NO_FLG);
    getFp(5'd13, 32'hbfc00000);
    getFp(5'd14, 32'h40000000);
    for (int i = 0; i < 10; i++) begin  // fclass sets bit i for value i
      putFp(5'd20, clsVal[i]);
      addRow(CLASS, 5'd0, 5'd20, 5'd0, 32'h0, 32'h0, 32'h1 << i, 32'h0, NO_FLG, 1'b0, 1'b0);
    end
    putFp(5'd21, 32'h3f800000);        // +1
    putFp(5'd22, 32'h40000000);        // +2
    putFp(5'd23, 32'h7fc00000);        // qNaN
    putFp(5'd24, 32'h7f800001);        // sNaN
    putFp(5'd25, 32'h80000000);        // -0
    putFp(5'd26, 32'h00000000);        // +0
    cmpOp(FEQ, 5'd21, 5'd21, 32'h1, NO_FLG);
    cmpOp(FEQ, 5'd21, 5'd22, 32'h0, NO_FLG);
    cmpOp(FLT, 5'd21, 5'd22, 32'h1, NO_FLG);
    cmpOp(FLT, 5'd22, 5'd21, 32'h0, NO_FLG);
    cmpOp(FLE, 5'd21, 5'd21, 32'h1, NO_FLG);
    cmpOp(FEQ, 5'd25, 5'd26, 32'h1, NO_FLG);   // -0 equals +0
    cmpOp(FLT, 5'd25, 5'd26, 32'h0, NO_FLG);
    cmpOp(FEQ, 5'd21, 5'd23, 32'h0, NO_FLG);   // Quiet compare
    cmpOp(FEQ, 5'd21, 5'd24, 32'h0, NV_SET);
    cmpOp(FLT, 5'd21, 5'd23, 32'h0, NV_SET);
    cmpOp(FLE, 5'd23, 5'd21, 32'h0, NV_SET);
    fpOp(MIN, 5'd27, 5'd25, 5'd26, NO_FLG);
    getFp(5'd27, 32'h80000000);
    fpOp(MAX, 5'd28, 5'd25, 5'd26, NO_FLG);
    getFp(5'd28, 32'h00000000);
    fpOp(MIN, 5'd29, 5'd21, 5'd23, NO_FLG);    // One NaN gives the number
    getFp(5'd29, 32'h3f800000);
    fpOp(MAX, 5'd30, 5'd23, 5'd24, NV_SET);    // Two NaNs give canonical NaN
    getFp(5'd30, 32'h7fc00000);
    fpOp(MIN, 5'd31, 5'd22, 5'd21, NO_FLG);
    getFp(5'd31, 32'h3f800000);
    // Illegal encodings write nothing
    putFp(5'd15, 32'h12345678);
    addRow(NONE, 5'd0, 5'd0, 5'd0, 32'h0, 32'h0, 32'h0, 32'h0, NO_FLG, 1'b0, 1'b0);
    addRow(SGNJN, 5'd15, 5'd10, 5'd10, 32'h0, 32'h0, 32'h0, 32'h0, NO_FLG, 1'b0, 1'b1);
    getFp(5'd15, 32'h12345678);
  endtask

  ////////////////////
  // Table runner with pE, pM and pW tracking the row in each stage
  task automatic runTable();
    int r = 0;
    int pE = -1;
    int pM = -1;
    int pW = -1;
    logic stalled;
    logic isInt;
    while (r < nRows || pE >= 0 || pM >= 0 || pW >= 0) begin
      instrD    = (r < nRows) ? rows[r].instr : 32'h0;
      statusFs  = (r < nRows && rows[r].fsOff) ? 2'b00 : 2'b11;
      srcAE     = (pE >= 0) ? rows[pE].srcA : 32'h0;   // Consumed in E
      readDataW = (pW >= 0) ? rows[pW].rdata : 32'h0;
      #1;
      stalled = fpuStallD;
      flushE  = stalled;                 // Core bubbles E on load-use
      if (stalled) stalls++;
      if (r < nRows) checkVal("illegalInstrD", 32'(illegalInstrD), 32'(rows[r].expIllegal));
      #5;
      if (pE >= 0) begin
        checkVal("fWriteIntE", 32'(fWriteIntE),
                 32'(!rows[pE].expIllegal && (rows[pE].op inside {FEQ, FLT, FLE, CLASS, MVXW})));
      end
      if (pM >= 0) begin
        isInt = !rows[pM].expIllegal && (rows[pM].op inside {FEQ, FLT, FLE, CLASS, MVXW});
        checkVal("fRegWriteM", 32'(fRegWriteM), 32'(rows[pM].expWrite));
        checkVal("setFflagsM", 32'(setFflagsM), 32'(rows[pM].expFlags));
        checkVal("fWriteIntM", 32'(fWriteIntM), 32'(isInt));
        checkVal("fpLoadStoreM", 32'(fpLoadStoreM),
                 32'(!rows[pM].expIllegal && (rows[pM].op inside {LOAD, STORE})));
        if (isInt) checkVal("fIntResM", fIntResM, rows[pM].expInt);
        if (rows[pM].op == STORE) checkVal("fWriteDataM", fWriteDataM, rows[pM].expData);
      end
      @(posedge clk);
      pW = pM;
      pM = pE;
      pE = (r < nRows && !stalled) ? r : -1;
      if (r < nRows && !stalled) r++;
      #1;
      flushE = 1'b0;
    end
  endtask

  ////////////////////
  // Main sequence
  initial begin
    rst = 1'b1;
    {stallE, stallM, stallW, flushE, flushM, flushW} = 6'b0;
    statusFs  = 2'b11;
    instrD    = 32'h0;
    srcAE     = 32'h0;
    readDataW = 32'h0;
    buildTable();
    nRows = rows.size();
    tableReady = 1'b1;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    checkVal("fRegWriteM", 32'(fRegWriteM), 32'h0);  // Control low after reset
    checkVal("fWriteIntM", 32'(fWriteIntM), 32'h0);
    checkVal("fpLoadStoreM", 32'(fpLoadStoreM), 32'h0);
    checkVal("fpuStallD", 32'(fpuStallD), 32'h0);
    checkVal("setFflagsM", 32'(setFflagsM), 32'h0);
    runTable();
    if (stalls != 1) begin
      $display("Load-use stall seen %0d times instead of once", stalls);
      errors++;
    end
    // One cycle with all stalls high holds M
    instrD = encode(MVXW, 5'd0, 5'd21, 5'd0);
    @(posedge clk);
    #1 instrD = 32'h0;
    @(posedge clk);
    #1 {stallE, stallM, stallW} = 3'b111;
    @(posedge clk);
    #1 {stallE, stallM, stallW} = 3'b000;
    checkVal("fIntResM", fIntResM, 32'h3f800000); // f21 holds +1
    checkVal("fWriteIntM", 32'(fWriteIntM), 32'h1);
    // Flushed instruction never reaches M
    instrD = encode(SGNJ, 5'd16, 5'd10, 5'd10);
    @(posedge clk);
    #1 instrD = 32'h0;
    flushM = 1'b1;
    @(posedge clk);
    #1 flushM = 1'b0;
    repeat (3) begin
      checkVal("fRegWriteM", 32'(fRegWriteM), 32'h0);
      @(posedge clk);
      #1;
    end
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog covers table, reset, drain and directed cycles
  initial begin
    wait (tableReady);
    #((nRows + 20) * 8);
    $display("Watchdog expired before the run finished");
    $display("TESTS FAILED");
    $finish;
  end
endmodule

//--- verilog.f
+incdir+logic
logic/fpPkg.sv
logic/fpUnpackedIf.sv
logic/fpUnpack.sv
logic/fpCompare.sv
logic/fpExecute.sv
logic/fpRegFile.sv
logic/fpHazard.sv
logic/fpuCtrl.sv
logic/fpu.sv
test/fpuTb.sv
